//--- hdl/eth_rx_pkg.sv
//////////////////////////////////////////////////////////////////////
// Shared constants, beat and status structs, and the write-state
// enum for the receive FIFO path
//////////////////////////////////////////////////////////////////////
`default_nettype none

package eth_rx_pkg;

    localparam int DATA_WIDTH      = 64;
    localparam int KEEP_WIDTH      = 8;
    localparam int PTP_TS_WIDTH    = 96;
    localparam int FIFO_DEPTH      = 64;
    localparam int FIFO_ADDR_WIDTH = 6;
    localparam int MAX_FRAME_BEATS = 32;
    localparam int TS_FIFO_DEPTH   = 16;
    localparam int TS_ADDR_WIDTH   = 4;

    typedef logic [PTP_TS_WIDTH-1:0] ptp_ts_t;

    // Bad flag is valid on the last beat, ts on the first beat
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
        logic                  bad;
        ptp_ts_t               ts;
    } rx_in_beat_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
        ptp_ts_t               ts;
    } rx_mem_word_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [KEEP_WIDTH-1:0] keep;
        logic                  last;
    } rx_out_beat_t;

    typedef struct packed {
        logic overflow;
        logic bad_frame;
        logic good_frame;
    } fifo_status_t;

    typedef enum logic {
        WR_STORE,
        WR_DROP
    } wr_state_e;

endpackage

`default_nettype wire

//--- hdl/frame_fifo_ram.sv
//////////////////////////////////////////////////////////////////////
// Beat memory for the frame FIFO, one write and one registered read
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module frame_fifo_ram
    import eth_rx_pkg::*;
(
    input  logic                       logic_clk,
    input  logic                       wr_en,
    input  logic [FIFO_ADDR_WIDTH-1:0] wr_addr,
    input  rx_mem_word_t               wr_data,
    input  logic                       rd_en,
    input  logic [FIFO_ADDR_WIDTH-1:0] rd_addr,
    output rx_mem_word_t               rd_data
);

    rx_mem_word_t mem [FIFO_DEPTH];

    always_ff @(posedge logic_clk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // Read word stays put until the next rd_en
    always_ff @(posedge logic_clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];
        end
    end

endmodule

`default_nettype wire

//--- hdl/rx_frame_fifo.sv
//////////////////////////////////////////////////////////////////////
// Frame-mode receive FIFO: commits good frames, drops bad, oversize
// and overflowing ones, and reports one-cycle status pulses
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rx_frame_fifo
    import eth_rx_pkg::*;
(
    input  logic         logic_clk,
    input  logic         logic_rst,
    input  rx_in_beat_t  in_beat,
    input  logic         in_valid,
    output rx_mem_word_t out_word,
    output logic         out_valid,
    input  logic         out_ready,
    output fifo_status_t status
);

    // Extra pointer bit tells full from empty
    logic [FIFO_ADDR_WIDTH:0] wr_ptr_commit;
    logic [FIFO_ADDR_WIDTH:0] wr_ptr_cur;
    logic [FIFO_ADDR_WIDTH:0] rd_ptr;

    logic [$clog2(MAX_FRAME_BEATS+1)-1:0] beat_cnt;
    wr_state_e    wr_state;

    rx_mem_word_t wr_word;
    rx_mem_word_t rd_word;
    logic         fifo_full;
    logic         ram_wr_en;
    logic         ran_out;
    logic         oversize;
    logic         ram_rd_en;
    logic         rd_valid;
    logic         out_load;

    always_comb begin
        wr_word.data = in_beat.data;
        wr_word.keep = in_beat.keep;
        wr_word.last = in_beat.last;
        wr_word.ts   = in_beat.ts;
    end

    assign fifo_full = (wr_ptr_cur[FIFO_ADDR_WIDTH] != rd_ptr[FIFO_ADDR_WIDTH]) &&
                       (wr_ptr_cur[FIFO_ADDR_WIDTH-1:0] == rd_ptr[FIFO_ADDR_WIDTH-1:0]);

    assign ram_wr_en = in_valid && (wr_state == WR_STORE) && !fifo_full;
    assign ran_out   = (wr_state == WR_DROP) || fifo_full;
    // Counter saturates, so this means more than MAX_FRAME_BEATS beats
    assign oversize  = (beat_cnt == MAX_FRAME_BEATS);

    // Write side
    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr_commit <= '0;
            wr_ptr_cur    <= '0;
            beat_cnt      <= '0;
            wr_state      <= WR_STORE;
            status        <= '0;
        end else begin
            status <= '0;
            if (in_valid) begin
                if (in_beat.last) begin
                    beat_cnt <= '0;
                    wr_state <= WR_STORE;
                    if (ran_out) begin
                        wr_ptr_cur      <= wr_ptr_commit;
                        status.overflow <= 1'b1;
                    end else if (in_beat.bad || oversize) begin
                        wr_ptr_cur       <= wr_ptr_commit;
                        status.bad_frame <= 1'b1;
                    end else begin
                        wr_ptr_cur        <= wr_ptr_cur + 1'b1;
                        wr_ptr_commit     <= wr_ptr_cur + 1'b1;
                        status.good_frame <= 1'b1;
                    end
                end else begin
                    if (beat_cnt < MAX_FRAME_BEATS) begin
                        beat_cnt <= beat_cnt + 1'b1;
                    end
                    if (ram_wr_en) begin
                        wr_ptr_cur <= wr_ptr_cur + 1'b1;
                    end else begin
                        // No room left so the rest of this frame is discarded
                        wr_state <= WR_DROP;
                    end
                end
            end
        end
    end

    // Memory register feeds a one-beat output register on the read side
    assign out_load  = !out_valid || out_ready;
    assign ram_rd_en = (rd_ptr != wr_ptr_commit) && (!rd_valid || out_load);

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            rd_ptr    <= '0;
            rd_valid  <= 1'b0;
            out_valid <= 1'b0;
        end else begin
            if (out_load) begin
                out_valid <= rd_valid;
            end
            if (ram_rd_en) begin
                rd_ptr   <= rd_ptr + 1'b1;
                rd_valid <= 1'b1;
            end else if (out_load) begin
                rd_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (out_load && rd_valid) begin
            out_word <= rd_word;
        end
    end

    frame_fifo_ram ram_inst (
        .logic_clk (logic_clk),
        .wr_en     (ram_wr_en),
        .wr_addr   (wr_ptr_cur[FIFO_ADDR_WIDTH-1:0]),
        .wr_data   (wr_word),
        .rd_en     (ram_rd_en),
        .rd_addr   (rd_ptr[FIFO_ADDR_WIDTH-1:0]),
        .rd_data   (rd_word)
    );

endmodule

`default_nettype wire

//--- hdl/ptp_ts_extract.sv
//////////////////////////////////////////////////////////////////////
// Captures the PTP timestamp of the first accepted beat of a frame
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ptp_ts_extract
    import eth_rx_pkg::*;
(
    input  logic    logic_clk,
    input  logic    logic_rst,
    input  logic    beat_accept,
    input  logic    beat_last,
    input  ptp_ts_t beat_ts,
    output ptp_ts_t ts,
    output logic    ts_valid
);

    logic first_beat;

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            first_beat <= 1'b1;
            ts_valid   <= 1'b0;
        end else begin
            ts_valid <= beat_accept && first_beat;
            // Next beat after a last one opens a new frame
            if (beat_accept) begin
                first_beat <= beat_last;
            end
        end
    end

    always_ff @(posedge logic_clk) begin
        if (beat_accept && first_beat) begin
            ts <= beat_ts;
        end
    end

endmodule

`default_nettype wire

//--- hdl/ptp_ts_fifo.sv
//////////////////////////////////////////////////////////////////////
// Small synchronous timestamp FIFO with valid/ready output
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module ptp_ts_fifo
    import eth_rx_pkg::*;
(
    input  logic    logic_clk,
    input  logic    logic_rst,
    input  ptp_ts_t in_ts,
    input  logic    in_valid,
    output ptp_ts_t out_ts,
    output logic    out_valid,
    input  logic    out_ready
);

    ptp_ts_t mem [TS_FIFO_DEPTH];

    logic [TS_ADDR_WIDTH-1:0] wr_ptr;
    logic [TS_ADDR_WIDTH-1:0] rd_ptr;
    logic [TS_ADDR_WIDTH:0]   count;
    logic                     push;
    logic                     pop;

    // Writes into a full FIFO are lost
    assign push      = in_valid && (count != TS_FIFO_DEPTH);
    assign pop       = out_valid && out_ready;
    assign out_valid = (count != '0);
    assign out_ts    = mem[rd_ptr];

    always_ff @(posedge logic_clk) begin
        if (push) begin
            mem[wr_ptr] <= in_ts;
        end
    end

    always_ff @(posedge logic_clk or posedge logic_rst) begin
        if (logic_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- hdl/eth_rx_fifo_ptp.sv
//////////////////////////////////////////////////////////////////////
// Receive path top: frame FIFO, timestamp extractor and
// timestamp FIFO on the logic clock
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module eth_rx_fifo_ptp
    import eth_rx_pkg::*;
(
    input  logic         logic_clk,
    input  logic         logic_rst,
    input  rx_in_beat_t  rx_in,
    input  logic         rx_in_valid,
    output rx_out_beat_t rx_out,
    output logic         rx_out_valid,
    input  logic         rx_out_ready,
    output ptp_ts_t      rx_ts,
    output logic         rx_ts_valid,
    input  logic         rx_ts_ready,
    output fifo_status_t rx_status
);

    rx_mem_word_t fifo_word;
    logic         beat_accept;
    ptp_ts_t      ext_ts;
    logic         ext_ts_valid;

    always_comb begin
        rx_out.data = fifo_word.data;
        rx_out.keep = fifo_word.keep;
        rx_out.last = fifo_word.last;
    end

    assign beat_accept = rx_out_valid && rx_out_ready;

    rx_frame_fifo frame_fifo_inst (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in_beat   (rx_in),
        .in_valid  (rx_in_valid),
        .out_word  (fifo_word),
        .out_valid (rx_out_valid),
        .out_ready (rx_out_ready),
        .status    (rx_status)
    );

    ptp_ts_extract ts_extract_inst (
        .logic_clk   (logic_clk),
        .logic_rst   (logic_rst),
        .beat_accept (beat_accept),
        .beat_last   (fifo_word.last),
        .beat_ts     (fifo_word.ts),
        .ts          (ext_ts),
        .ts_valid    (ext_ts_valid)
    );

    ptp_ts_fifo ts_fifo_inst (
        .logic_clk (logic_clk),
        .logic_rst (logic_rst),
        .in_ts     (ext_ts),
        .in_valid  (ext_ts_valid),
        .out_ts    (rx_ts),
        .out_valid (rx_ts_valid),
        .out_ready (rx_ts_ready)
    );

endmodule

`default_nettype wire

//--- sim/rx_checker.sv
//////////////////////////////////////////////////////////////////////
// Reference queues and comparison of output beats, timestamps
// and status pulses at the top-level ports
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rx_checker
    import eth_rx_pkg::*;
(
    input  logic         logic_clk,
    input  logic         logic_rst,
    input  rx_out_beat_t rx_out,
    input  logic         rx_out_valid,
    input  logic         rx_out_ready,
    input  ptp_ts_t      rx_ts,
    input  logic         rx_ts_valid,
    input  logic         rx_ts_ready,
    input  fifo_status_t rx_status
);

    rx_out_beat_t exp_beats [$];
    ptp_ts_t      exp_ts [$];
    fifo_status_t exp_status [$];
    int           error_count = 0;

    // Beat i carries base + i, full keep except on the last beat
    task automatic add_frame(input int nbeats, input logic [63:0] base,
                             input logic [7:0] last_keep, input ptp_ts_t ts,
                             input byte outcome);
        rx_out_beat_t b;
        fifo_status_t s;
        s = '0;
        if (outcome == "G") begin
            for (int i = 0; i < nbeats; i++) begin
                b.data = base + i;
                b.last = (i == nbeats - 1);
                b.keep = b.last ? last_keep : 8'hff;
                exp_beats.push_back(b);
            end
            exp_ts.push_back(ts);
            s.good_frame = 1'b1;
        end else if (outcome == "B") begin
            s.bad_frame = 1'b1;
        end else begin
            s.overflow = 1'b1;
        end
        exp_status.push_back(s);
    endtask

    function automatic int pending();
        return exp_beats.size() + exp_ts.size() + exp_status.size();
    endfunction

    always @(posedge logic_clk) begin
        rx_out_beat_t eb;
        ptp_ts_t      et;
        fifo_status_t es;
        if (!logic_rst) begin
            if (rx_out_valid && rx_out_ready) begin
                if (exp_beats.size() == 0) begin
                    $display("Output beat arrived when no beat was expected");
                    error_count++;
                end else begin
                    eb = exp_beats.pop_front();
                    if (rx_out !== eb) begin
                        $display("Mismatch rx_out: got %h expected %h", rx_out, eb);
                        error_count++;
                    end
                end
            end
            if (rx_ts_valid && rx_ts_ready) begin
                if (exp_ts.size() == 0) begin
                    $display("Timestamp arrived when no timestamp was expected");
                    error_count++;
                end else begin
                    et = exp_ts.pop_front();
                    if (rx_ts !== et) begin
                        $display("Mismatch rx_ts: got %h expected %h", rx_ts, et);
                        error_count++;
                    end
                end
            end
            if (rx_status != '0) begin
                if (exp_status.size() == 0) begin
                    $display("Status pulse seen with no frame pending");
                    error_count++;
                end else begin
                    es = exp_status.pop_front();
                    if (rx_status !== es) begin
                        $display("Mismatch rx_status: got %h expected %h", rx_status, es);
                        error_count++;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- sim/rx_assertions.sv
//////////////////////////////////////////////////////////////////////
// Handshake and status assertions bound into the receive top
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module rx_assertions
    import eth_rx_pkg::*;
(
    input logic         logic_clk,
    input logic         logic_rst,
    input rx_out_beat_t rx_out,
    input logic         rx_out_valid,
    input logic         rx_out_ready,
    input ptp_ts_t      rx_ts,
    input logic         rx_ts_valid,
    input logic         rx_ts_ready,
    input fifo_status_t rx_status
);

    int fail_count = 0;

    out_hold: assert property (@(posedge logic_clk) disable iff (logic_rst)
        rx_out_valid && !rx_out_ready |=> rx_out_valid && $stable(rx_out))
        else begin
            fail_count++;
            $error("rx_out changed while stalled");
        end

    ts_hold: assert property (@(posedge logic_clk) disable iff (logic_rst)
        rx_ts_valid && !rx_ts_ready |=> rx_ts_valid && $stable(rx_ts))
        else begin
            fail_count++;
            $error("rx_ts changed while stalled");
        end

    status_onehot: assert property (@(posedge logic_clk) disable iff (logic_rst)
        $onehot0(rx_status))
        else begin
            fail_count++;
            $error("more than one status bit high");
        end

    reset_quiet: assert property (@(posedge logic_clk)
        logic_rst |-> !rx_out_valid && !rx_ts_valid)
        else begin
            fail_count++;
            $error("output valid high in reset");
        end

endmodule

bind eth_rx_fifo_ptp rx_assertions u_assert (.*);

`default_nettype wire

//--- sim/tb_eth_rx_fifo_ptp.sv
//////////////////////////////////////////////////////////////////////
// Testbench for the receive FIFO path: clock, reset, frames read
// from the data file, LCG back-pressure and the closing summary
//////////////////////////////////////////////////////////////////////
`timescale 1ns/100ps
`default_nettype none

module tb_eth_rx_fifo_ptp;
    import eth_rx_pkg::*;

    logic         logic_clk;
    logic         logic_rst;
    rx_in_beat_t  rx_in;
    logic         rx_in_valid;
    rx_out_beat_t rx_out;
    logic         rx_out_valid;
    logic         rx_out_ready;
    ptp_ts_t      rx_ts;
    logic         rx_ts_valid;
    logic         rx_ts_ready;
    fifo_status_t rx_status;

    // 0 random readies, 1 stall, 2 drain
    int          ready_mode;
    logic [31:0] lcg_state;
    int          timeout_count;

    eth_rx_fifo_ptp u_dut (.*);

    rx_checker u_chk (.*);

    initial begin
        logic_clk = 1'b0;
        forever #20 logic_clk = ~logic_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Out ready about half the time, ts ready three quarters
    initial begin
        lcg_state = 32'hcb7e_b386;
        forever begin
            @(posedge logic_clk);
            #1;
            lcg_state = lcg_next(lcg_state);
            rx_ts_ready = (lcg_state[29:28] != 2'b00);
            case (ready_mode)
                1:       rx_out_ready = 1'b0;
                2:       rx_out_ready = 1'b1;
                default: rx_out_ready = lcg_state[31];
            endcase
        end
    end

    task automatic send_frame(input int nbeats, input logic [63:0] base,
                              input logic [7:0] last_keep, input int bad,
                              input ptp_ts_t ts, input int gap);
        for (int i = 0; i < nbeats; i++) begin
            @(posedge logic_clk);
            #1;
            rx_in.data  = base + i;
            rx_in.last  = (i == nbeats - 1);
            rx_in.keep  = rx_in.last ? last_keep : 8'hff;
            rx_in.bad   = rx_in.last ? bad[0] : 1'b0;
            rx_in.ts    = ts + i;
            rx_in_valid = 1'b1;
        end
        @(posedge logic_clk);
        #1;
        rx_in_valid = 1'b0;
        repeat (gap) @(posedge logic_clk);
    endtask

    task automatic finish_run();
        int chk_err;
        int asrt_err;
        chk_err  = u_chk.error_count;
        asrt_err = u_dut.u_assert.fail_count;
        $display("Errors: checker %0d, assertions %0d, timeouts %0d",
                 chk_err, asrt_err, timeout_count);
        if (chk_err == 0 && asrt_err == 0 && timeout_count == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    endtask

    // Everything expected so far has to come out before the limit
    task automatic wait_drained(input int max_cycles);
        int n;
        n = 0;
        while (u_chk.pending() != 0 && n < max_cycles) begin
            @(posedge logic_clk);
            n++;
        end
        if (u_chk.pending() != 0) begin
            $display("Timeout: %0d expected items still pending after %0d cycles",
                     u_chk.pending(), max_cycles);
            timeout_count++;
            finish_run();
        end
    endtask

    initial begin
        int      fd;
        int      nf;
        string   line;
        byte     phase;
        byte     prev_phase;
        byte     outcome;
        int      nbeats;
        int      bad;
        int      gap;
        logic [63:0] base;
        logic [7:0]  last_keep;
        ptp_ts_t     ts;

        logic_rst     = 1'b1;
        rx_in         = '0;
        rx_in_valid   = 1'b0;
        rx_out_ready  = 1'b0;
        rx_ts_ready   = 1'b0;
        ready_mode    = 0;
        timeout_count = 0;
        prev_phase    = "R";
        repeat (16) @(posedge logic_clk);
        #1;
        logic_rst = 1'b0;
        repeat (4) @(posedge logic_clk);

        fd = $fopen("sim/rx_input_frames.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file sim/rx_input_frames.txt");
            u_chk.error_count++;
        end else begin
            while ($fgets(line, fd)) begin
                if (line.len() > 2 && line[0] != "#") begin
                    nf = $sscanf(line, "%c %d %h %h %d %h %d %c",
                                 phase, nbeats, base, last_keep, bad, ts, gap, outcome);
                    if (nf != 8) begin
                        $display("Stimulus line could not be parsed: %s", line);
                        u_chk.error_count++;
                    end else begin
                        // Phase change starts from an empty FIFO
                        if (phase != prev_phase) begin
                            ready_mode = 2;
                            wait_drained(5000);
                            ready_mode = (phase == "S") ? 1 : 0;
                            prev_phase = phase;
                        end
                        u_chk.add_frame(nbeats, base, last_keep, ts, outcome);
                        send_frame(nbeats, base, last_keep, bad, ts, gap);
                    end
                end
            end
            $fclose(fd);
        end

        wait_drained(5000);
        // Stray beats or timestamps would show up here
        repeat (40) @(posedge logic_clk);
        finish_run();
    end

endmodule

`default_nettype wire

//--- files.f
hdl/eth_rx_pkg.sv
hdl/frame_fifo_ram.sv
hdl/rx_frame_fifo.sv
hdl/ptp_ts_extract.sv
hdl/ptp_ts_fifo.sv
hdl/eth_rx_fifo_ptp.sv
sim/rx_checker.sv
sim/rx_assertions.sv
sim/tb_eth_rx_fifo_ptp.sv

//--- sim/rx_input_frames.txt
# phase beats data_base last_keep bad first_ts gap outcome, one frame per line
# phase R random readies, S rx_out_ready low; outcome G good, B bad or oversize, O overflow
R 1  1000000000000000 ff 0 000000010000000000000001 2  G
R 2  2000000000000000 0f 0 000000020000000000000002 0  G
R 3  3000000000000000 01 0 000000030000000000000003 3  G
R 4  4000000000000000 ff 1 000000040000000000000004 1  B
R 5  5000000000000000 3f 0 000000050000000000000005 0  G
R 8  6000000000000000 7f 0 000000060000000000000006 4  G
R 12 7000000000000000 ff 1 000000070000000000000007 2  B
R 16 8000000000000000 03 0 000000080000000000000008 5  G
R 31 9000000000000000 ff 0 000000090000000000000009 20 G
R 32 a000000000000000 1f 0 0000000a000000000000000a 20 G
R 33 b000000000000000 ff 0 0000000b000000000000000b 20 B
R 1  c000000000000000 ff 1 0000000c000000000000000c 0  B
R 1  c100000000000000 07 0 0000000c100000000000000c 0  G
R 6  c200000000000000 ff 0 0000000c200000000000000c 2  G
S 20 d000000000000000 ff 0 0000000d000000000000000d 3  G
S 20 d100000000000000 0f 0 0000000d100000000000000d 1  G
S 20 d200000000000000 ff 0 0000000d200000000000000d 1  G
S 10 d300000000000000 ff 0 0000000d300000000000000d 1  O
S 4  d400000000000000 01 0 0000000d400000000000000d 2  G
R 7  e000000000000000 ff 0 0000000e000000000000000e 1  G
R 1  e100000000000000 ff 0 0000000e100000000000000e 0  G
R 2  e200000000000000 ff 1 0000000e200000000000000e 0  B
R 9  e300000000000000 3f 0 0000000e300000000000000e 3  G
R 32 f000000000000000 ff 0 0000000f000000000000000f 5  G
